//--- common/manycore_mem_pkg.sv
package manycore_mem_pkg;

   // --------------------
   // widths
   // --------------------

   // one host word
   localparam int data_width_gp = 32;

   // word address, covers every bank together
   localparam int addr_width_gp = 12;

   // byte lanes per word
   localparam int mask_width_gp = data_width_gp / 8;

   // enough for 16 banks
   localparam int bank_id_width_gp = 4;

   // global cycle counter
   localparam int ctr_width_gp = 64;

   // --------------------
   // vector types
   // --------------------

   typedef logic [data_width_gp-1:0] data_t;
   typedef logic [addr_width_gp-1:0] addr_t;
   typedef logic [mask_width_gp-1:0] mask_t;
   typedef logic [bank_id_width_gp-1:0] bank_id_t;
   typedef logic [ctr_width_gp-1:0] ctr_t;

   // last word of the address space, a write here means print-stat
   localparam addr_t print_stat_addr_gp = '1;

   // --------------------
   // host link payloads
   // --------------------

   // request from the host link
   typedef struct packed {
      logic  write_not_read;
      addr_t addr;
      data_t data;
      mask_t mask;
   } mem_req_s;

   // response back to the host, tagged with the answering bank
   // data is zero for writes
   typedef struct packed {
      logic     write_not_read;
      bank_id_t bank_id;
      data_t    data;
   } mem_rsp_s;

endpackage

//--- mem_system/mem_bank.sv
`timescale 1ns/100ps

module mem_bank #(
   parameter int num_banks_p = 4,
   localparam int index_width_lp = manycore_mem_pkg::addr_width_gp - $clog2(num_banks_p)
) (
   input  logic                      core_clk,

   // access strobe from the router, one bank at a time
   input  logic                      en_i,
   input  logic                      write_not_read_i,
   input  logic [index_width_lp-1:0] index_i,
   input  manycore_mem_pkg::mask_t   mask_i,
   input  manycore_mem_pkg::data_t   data_i,

   output manycore_mem_pkg::data_t   rdata_o
);

   import manycore_mem_pkg::*;

   // words per bank
   localparam int depth_lp = 1 << index_width_lp;

   // bits per mask lane
   localparam int lane_width_lp = data_width_gp / mask_width_gp;

   data_t mem_r [depth_lp];
   data_t rdata_r;

   // --------------------
   // storage
   // --------------------

   // only lanes with their mask bit set are written
   always_ff @(posedge core_clk) begin
      if (en_i && write_not_read_i) begin
         for (int i = 0; i < mask_width_gp; i++) begin
            if (mask_i[i]) begin
               mem_r[index_i][i*lane_width_lp +: lane_width_lp]
                  <= data_i[i*lane_width_lp +: lane_width_lp];
            end
         end
      end
   end

   // --------------------
   // read port
   // --------------------

   // loads on reads only
   // holds through writes and idle cycles, which keeps a stalled response stable
   always_ff @(posedge core_clk) begin
      if (en_i && !write_not_read_i) begin
         rdata_r <= mem_r[index_i];
      end
   end

   assign rdata_o = rdata_r;

endmodule

//--- mem_system/mem_bank_router.sv
`timescale 1ns/100ps

module mem_bank_router #(
   parameter int num_banks_p = 4
) (
   input  logic                         core_clk,
   input  logic                         rst_n_i,

   // request, already qualified by the top level
   input  logic                         req_fire_i,
   input  manycore_mem_pkg::mem_req_s   req_i,
   output logic                         req_ready_o,

   // response channel
   output logic                         rsp_v_o,
   output manycore_mem_pkg::mem_rsp_s   rsp_o,
   input  logic                         rsp_ready_i
);

   import manycore_mem_pkg::*;

   localparam int bank_sel_width_lp = $clog2(num_banks_p);
   localparam int index_width_lp = addr_width_gp - bank_sel_width_lp;

   logic [bank_sel_width_lp-1:0] bank_sel;
   logic [index_width_lp-1:0]    bank_index;
   logic [num_banks_p-1:0]       bank_en;
   data_t                        bank_rdata [num_banks_p];

   logic     rsp_v_r;
   logic     rsp_wnr_r;
   bank_id_t rsp_bank_r;
   data_t    rsp_rdata;

   // --------------------
   // address decode
   // --------------------

   // high bits pick the bank, the rest index inside it
   assign bank_sel   = req_i.addr[addr_width_gp-1 -: bank_sel_width_lp];
   assign bank_index = req_i.addr[index_width_lp-1:0];

   for (genvar b = 0; b < num_banks_p; b++) begin : g_bank
      // strobe only on acceptance so a held response keeps its read data
      assign bank_en[b] = req_fire_i && (bank_sel == (bank_sel_width_lp)'(b));

      mem_bank #(
         .num_banks_p(num_banks_p)
      ) u_bank (
         .core_clk         (core_clk),
         .en_i             (bank_en[b]),
         .write_not_read_i (req_i.write_not_read),
         .index_i          (bank_index),
         .mask_i           (req_i.mask),
         .data_i           (req_i.data),
         .rdata_o          (bank_rdata[b])
      );
   end

   // --------------------
   // response register
   // --------------------
   always_ff @(posedge core_clk) begin
      if (!rst_n_i) begin
         rsp_v_r <= 1'b0;
      end else if (req_fire_i) begin
         rsp_v_r <= 1'b1;
      end else if (rsp_ready_i) begin
         rsp_v_r <= 1'b0;
      end
   end

   always_ff @(posedge core_clk) begin
      if (req_fire_i) begin
         rsp_wnr_r  <= req_i.write_not_read;
         rsp_bank_r <= bank_id_t'(bank_sel);
      end
   end

   // bank read registers already line up with the response cycle
   assign rsp_rdata = bank_rdata[rsp_bank_r[bank_sel_width_lp-1:0]];

   assign rsp_o.write_not_read = rsp_wnr_r;
   assign rsp_o.bank_id        = rsp_bank_r;
   assign rsp_o.data           = rsp_wnr_r ? '0 : rsp_rdata;
   assign rsp_v_o              = rsp_v_r;

   // a consumed response frees the slot in the same cycle
   assign req_ready_o = !rsp_v_r || rsp_ready_i;

endmodule

//--- hdl/global_cycle_counter.sv
`timescale 1ns/100ps

module global_cycle_counter #(
   parameter int reset_depth_p = 2
) (
   input  logic                     core_clk,
   input  logic                     rst_n_i,
   output manycore_mem_pkg::ctr_t   global_ctr_o
);

   import manycore_mem_pkg::*;

   // ones shift in behind the release of reset
   logic [reset_depth_p-1:0] rst_dly_r;
   logic                     ctr_run;
   ctr_t                     ctr_r;

   // --------------------
   // reset delay chain
   // --------------------
   always_ff @(posedge core_clk) begin
      if (!rst_n_i) begin
         rst_dly_r <= '0;
      end else begin
         rst_dly_r[0] <= 1'b1;
         for (int i = 1; i < reset_depth_p; i++) begin
            rst_dly_r[i] <= rst_dly_r[i-1];
         end
      end
   end

   // same depth the tile array sees on its reset
   assign ctr_run = rst_dly_r[reset_depth_p-1];

   // --------------------
   // cycle counter
   // --------------------
   always_ff @(posedge core_clk) begin
      if (!rst_n_i || !ctr_run) begin
         ctr_r <= '0;
      end else begin
         ctr_r <= ctr_r + ctr_t'(1);
      end
   end

   assign global_ctr_o = ctr_r;

endmodule

//--- hdl/print_stat_snoop.sv
`timescale 1ns/100ps

module print_stat_snoop (
   input  logic                         core_clk,
   input  logic                         rst_n_i,

   // accepted request on the host link
   input  logic                         req_fire_i,
   input  manycore_mem_pkg::mem_req_s   req_i,

   output logic                         print_stat_v_o,
   output manycore_mem_pkg::data_t      print_stat_tag_o
);

   import manycore_mem_pkg::*;

   logic  stat_hit;
   logic  stat_v_r;
   data_t stat_tag_r;

   // only accepted writes to the stat word count
   assign stat_hit = req_fire_i
                  && req_i.write_not_read
                  && (req_i.addr == print_stat_addr_gp);

   // single cycle pulse, a new hit on the next cycle pulses again
   always_ff @(posedge core_clk) begin
      if (!rst_n_i) begin
         stat_v_r <= 1'b0;
      end else begin
         stat_v_r <= stat_hit;
      end
   end

   // tag holds the last stat write data
   always_ff @(posedge core_clk) begin
      if (stat_hit) begin
         stat_tag_r <= req_i.data;
      end
   end

   assign print_stat_v_o   = stat_v_r;
   assign print_stat_tag_o = stat_tag_r;

endmodule

//--- hdl/manycore_mem_top.sv
`timescale 1ns/100ps

module manycore_mem_top #(
   parameter int num_banks_p = 4,
   parameter int reset_depth_p = 2
) (
   input  logic                         core_clk,
   input  logic                         rst_n_i,

   // host request link
   input  logic                         req_v_i,
   input  manycore_mem_pkg::mem_req_s   req_i,
   output logic                         req_ready_o,

   // host response link
   output logic                         rsp_v_o,
   output manycore_mem_pkg::mem_rsp_s   rsp_o,
   input  logic                         rsp_ready_i,

   // print-stat snoop
   output logic                         print_stat_v_o,
   output manycore_mem_pkg::data_t      print_stat_tag_o,

   // free-running cycle count
   output manycore_mem_pkg::ctr_t       global_ctr_o
);

   // one acceptance strobe shared by snoop and router
   logic req_fire;
   logic req_ready;

   assign req_fire = req_v_i && req_ready;
   assign req_ready_o = req_ready;

   // --------------------
   // global counter
   // --------------------
   global_cycle_counter #(
      .reset_depth_p(reset_depth_p)
   ) u_global_ctr (
      .core_clk     (core_clk),
      .rst_n_i      (rst_n_i),
      .global_ctr_o (global_ctr_o)
   );

   // --------------------
   // host link snoop
   // --------------------
   print_stat_snoop u_print_stat_snoop (
      .core_clk         (core_clk),
      .rst_n_i          (rst_n_i),
      .req_fire_i       (req_fire),
      .req_i            (req_i),
      .print_stat_v_o   (print_stat_v_o),
      .print_stat_tag_o (print_stat_tag_o)
   );

   // --------------------
   // banked memory
   // --------------------
   mem_bank_router #(
      .num_banks_p(num_banks_p)
   ) u_mem_router (
      .core_clk    (core_clk),
      .rst_n_i     (rst_n_i),
      .req_fire_i  (req_fire),
      .req_i       (req_i),
      .req_ready_o (req_ready),
      .rsp_v_o     (rsp_v_o),
      .rsp_o       (rsp_o),
      .rsp_ready_i (rsp_ready_i)
   );

endmodule

//--- verification/manycore_mem_tb.sv
`timescale 1ns/100ps

module manycore_mem_tb;

   import manycore_mem_pkg::*;

   localparam int num_banks_lp = 4;
   localparam int reset_depth_lp = 2;
   localparam int bank_sel_w_lp = $clog2(num_banks_lp);
   localparam int index_w_lp = addr_width_gp - bank_sel_w_lp;
   localparam int pool_size_lp = 33;
   localparam int timeout_lp = 64;
   localparam int random_ops_lp = 400;

   logic     core_clk;
   logic     rst_n;
   logic     req_v;
   mem_req_s req;
   logic     req_ready;
   logic     rsp_v;
   mem_rsp_s rsp;
   logic     rsp_ready;
   logic     stat_v;
   data_t    stat_tag;
   ctr_t     global_ctr;

   // reference model of the whole word space
   data_t    model_mem [1 << addr_width_gp];
   mem_rsp_s exp_q [$];
   addr_t    pool [pool_size_lp];

   // what happened at the last edge, seen from the following negedge
   logic     fired_q;
   logic     consumed_q;
   logic     held_q;
   mem_req_s fired_req;
   mem_rsp_s held_rsp;
   logic     exp_rsp_v;
   int       edges_since_rst;
   int       accept_cnt;
   int       consume_cnt;

   manycore_mem_top #(
      .num_banks_p(num_banks_lp),
      .reset_depth_p(reset_depth_lp)
   ) dut (
      .core_clk         (core_clk),
      .rst_n_i          (rst_n),
      .req_v_i          (req_v),
      .req_i            (req),
      .req_ready_o      (req_ready),
      .rsp_v_o          (rsp_v),
      .rsp_o            (rsp),
      .rsp_ready_i      (rsp_ready),
      .print_stat_v_o   (stat_v),
      .print_stat_tag_o (stat_tag),
      .global_ctr_o     (global_ctr)
   );

   initial begin
      core_clk = 1'b0;
      forever #20 core_clk = ~core_clk;
   end

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
         $display("ERRORS FOUND");
         $fatal(1);
      end
   endtask

   function automatic data_t merge_masked_word(input data_t old_word, input data_t new_word,
                                               input mask_t mask);
      data_t merged;
      merged = old_word;
      for (int i = 0; i < mask_width_gp; i++) begin
         if (mask[i]) begin
            merged[i*8 +: 8] = new_word[i*8 +: 8];
         end
      end
      return merged;
   endfunction

   // --------------------
   // model update at acceptance
   // --------------------
   task automatic accept_req(input mem_req_s r);
      mem_rsp_s e;
      e.write_not_read = r.write_not_read;
      e.bank_id = bank_id_t'(r.addr[addr_width_gp-1 -: bank_sel_w_lp]);
      if (r.write_not_read) begin
         e.data = '0;
         model_mem[r.addr] = merge_masked_word(model_mem[r.addr], r.data, r.mask);
      end else begin
         e.data = model_mem[r.addr];
      end
      exp_q.push_back(e);
      accept_cnt++;
   endtask

   // outputs after the last edge, compared at the negedge
   task automatic check_outputs();
      logic exp_stat;
      ctr_t exp_ctr;
      edges_since_rst++;
      if (fired_q) begin
         exp_rsp_v = 1'b1;
      end else if (consumed_q) begin
         exp_rsp_v = 1'b0;
      end
      check_value("rsp_v_o", 64'(rsp_v), 64'(exp_rsp_v));
      if (held_q) begin
         check_value("rsp_o (held)", 64'(rsp), 64'(held_rsp));
      end
      exp_stat = fired_q && fired_req.write_not_read && (fired_req.addr == print_stat_addr_gp);
      check_value("print_stat_v_o", 64'(stat_v), 64'(exp_stat));
      if (exp_stat) begin
         check_value("print_stat_tag_o", 64'(stat_tag), 64'(fired_req.data));
      end
      // counter stays at zero for the reset delay, then counts every edge
      exp_ctr = (edges_since_rst > reset_depth_lp) ? ctr_t'(edges_since_rst - reset_depth_lp)
                                                   : '0;
      check_value("global_ctr_o", global_ctr, exp_ctr);
   endtask

   // one clock cycle: check, drive on the falling edge, resolve handshakes
   task automatic run_cycle(input logic v, input mem_req_s r, input logic ready,
                            output logic fired);
      logic consumed;
      @(negedge core_clk);
      check_outputs();
      req_v = v;
      req = r;
      rsp_ready = ready;
      #1;
      check_value("req_ready_o", 64'(req_ready), 64'(!exp_rsp_v || ready));
      fired = v && req_ready;
      consumed = rsp_v && ready;
      if (consumed) begin
         if (exp_q.size() == 0) begin
            $display("response consumed with no request outstanding at %0t", $time);
            $display("ERRORS FOUND");
            $fatal(1);
         end
         check_value("rsp_o", 64'(rsp), 64'(exp_q.pop_front()));
         consume_cnt++;
      end
      if (fired) begin
         accept_req(r);
      end
      fired_q = fired;
      fired_req = r;
      consumed_q = consumed;
      held_q = rsp_v && !ready;
      held_rsp = rsp;
   endtask

   // holds the request until accepted, stalling the response side at random
   task automatic send_req(input mem_req_s r, input int stall_pct, output int tries);
      logic fired;
      logic ready;
      tries = 0;
      fired = 1'b0;
      while (!fired) begin
         if (tries == timeout_lp) begin
            $display("timeout: request to address 0x%h was never accepted", r.addr);
            $display("ERRORS FOUND");
            $fatal(1);
         end
         ready = ($urandom % 100) >= stall_pct;
         run_cycle(1'b1, r, ready, fired);
         tries++;
      end
   endtask

   task automatic idle_cycles(input int n);
      logic fired;
      for (int i = 0; i < n; i++) begin
         run_cycle(1'b0, '0, 1'b1, fired);
      end
   endtask

   task automatic drain_responses();
      logic fired;
      int waited;
      waited = 0;
      while (exp_q.size() != 0) begin
         if (waited == timeout_lp) begin
            $display("timeout: outstanding response was never returned");
            $display("ERRORS FOUND");
            $fatal(1);
         end
         run_cycle(1'b0, '0, 1'b1, fired);
         waited++;
      end
   endtask

   initial begin
      mem_req_s r;
      mem_req_s wr;
      logic     fired;
      int       tries;
      int       idx;
      void'($urandom(32'h1395));
      rst_n = 1'b0;
      req_v = 1'b0;
      req = '0;
      rsp_ready = 1'b0;
      fired_q = 1'b0;
      consumed_q = 1'b0;
      held_q = 1'b0;
      fired_req = '0;
      held_rsp = '0;
      exp_rsp_v = 1'b0;
      edges_since_rst = 0;
      accept_cnt = 0;
      consume_cnt = 0;
      // eight words per bank, plus the stat word at the top
      for (int i = 0; i < pool_size_lp - 1; i++) begin
         pool[i] = addr_t'(((i % num_banks_lp) << index_w_lp)
                           | ((i * 37 + 5) % (1 << index_w_lp)));
      end
      pool[pool_size_lp-1] = print_stat_addr_gp;

      repeat (2) @(negedge core_clk);
      check_value("rsp_v_o", 64'(rsp_v), 64'(0));
      check_value("print_stat_v_o", 64'(stat_v), 64'(0));
      check_value("global_ctr_o", global_ctr, '0);
      rst_n = 1'b1;
      idle_cycles(reset_depth_lp + 4);

      // --------------------
      // full-mask fill, then read back at full rate
      // --------------------
      for (int i = 0; i < pool_size_lp; i++) begin
         r.write_not_read = 1'b1;
         r.addr = pool[i];
         r.data = $urandom;
         r.mask = '1;
         send_req(r, 0, tries);
         check_value("req accept cycles", 64'(tries), 64'(1));
      end
      for (int i = 0; i < pool_size_lp; i++) begin
         r = '0;
         r.addr = pool[i];
         send_req(r, 0, tries);
         check_value("req accept cycles", 64'(tries), 64'(1));
      end

      // random masked traffic with response stalls
      for (int n = 0; n < random_ops_lp; n++) begin
         idx = int'($urandom % pool_size_lp);
         r.write_not_read = ($urandom % 2) != 0;
         r.addr = pool[idx];
         r.data = $urandom;
         r.mask = mask_t'($urandom);
         send_req(r, 25, tries);
      end

      // --------------------
      // long stall with a request waiting
      // --------------------
      r = '0;
      r.addr = pool[3];
      send_req(r, 0, tries);
      wr.write_not_read = 1'b1;
      wr.addr = print_stat_addr_gp;
      wr.data = $urandom;
      wr.mask = mask_t'($urandom);
      for (int i = 0; i < 6; i++) begin
         run_cycle(1'b1, wr, 1'b0, fired);
         check_value("req_v_i && req_ready_o", 64'(fired), 64'(0));
      end
      send_req(wr, 0, tries);

      drain_responses();
      idle_cycles(2);
      check_value("response count", 64'(consume_cnt), 64'(accept_cnt));
      $display("NO ERRORS");
      $finish;
   end

endmodule

//--- manycore_mem.f
common/manycore_mem_pkg.sv
mem_system/mem_bank.sv
mem_system/mem_bank_router.sv
hdl/global_cycle_counter.sv
hdl/print_stat_snoop.sv
hdl/manycore_mem_top.sv
verification/manycore_mem_tb.sv

//--- Makefile
TOP := manycore_mem_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f manycore_mem.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f manycore_mem.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
